// File: include/sb_link_config.svh
`ifndef SB_LINK_CONFIG_SVH
`define SB_LINK_CONFIG_SVH

// --------------------------------------------------------------------------
// Sideband link build options
// --------------------------------------------------------------------------

// Width of one payload flit on the narrow channel
// Only 8 and 16 are meaningful, a dword then takes 4 or 2 flits
`define SB_PLD_BITS 8

// Port id of this endpoint
// Messages whose header dest differs are dropped whole by the filter
`define SB_LOCAL_PORT 8'h5A

`endif

// File: rtl/sb_link_pkg.sv
`include "sb_link_config.svh"

package sb_link_pkg;

    // ----------------------------------------------------------------------
    // Dword views
    // ----------------------------------------------------------------------

    // Header layout of the first dword of every message, MSB first
    typedef struct packed {
        logic [7:0] dest;
        logic [7:0] src;
        logic [7:0] opcode;
        logic [2:0] tag;
        logic [4:0] rsvd;
    } sb_hdr_t;

    // The same 32 bits read either as plain data or as header fields
    typedef union packed {
        logic [31:0] raw;
        sb_hdr_t     hdr;
    } sb_dword_u;

    // One dword as it enters the serializer and leaves the deserializer
    typedef struct packed {
        sb_dword_u data;
        logic      eom;
    } sb_dword_t;

    // ----------------------------------------------------------------------
    // Channel and output beats
    // ----------------------------------------------------------------------

    // One flit on the narrow channel
    // Eom rides only on the final flit of the final dword of a message
    typedef struct packed {
        logic [`SB_PLD_BITS-1:0] pld;
        logic                    eom;
    } sb_flit_t;

    // A dword delivered to the local agent, tagged with its place in the message
    typedef struct packed {
        sb_dword_u data;
        logic      eom;
        logic      is_header;
    } sb_rx_t;

endpackage

// File: rtl/sb_byte_count.sv
`timescale 1ns/1ps
`include "sb_link_config.svh"

module sb_byte_count #(
    parameter int pld_bits = `SB_PLD_BITS
) (
    input  logic side_clk,
    input  logic side_rst_b,
    input  logic valid,
    output logic first_byte,
    output logic second_byte,
    output logic third_byte,
    output logic last_byte
);

    // The final flit of a dword has count 3 at 8 bits and count 1 at 16 bits
    localparam logic [1:0] last_cnt = 2'((32 / pld_bits) - 1);

    logic [1:0] byte_count;

    // Position marks come straight from the count
    // At 16 bits the second flit is already the last one, so the third mark
    // points at count 1 there as well
    always_comb
    begin
        second_byte = (byte_count == 2'd1);
        if (pld_bits == 16)
            third_byte = (byte_count == 2'd1);
        else
            third_byte = (byte_count == 2'd2);
        last_byte = (byte_count == last_cnt);
    end

    // The first mark is qualified so it pulses only for a real transfer
    assign first_byte = (byte_count == 2'd0) & valid;

    // Step on every transfer and wrap back to zero after the final flit
    always_ff @(posedge side_clk or negedge side_rst_b)
    begin
        if (!side_rst_b)
        begin
            byte_count <= 2'd0;
        end
        else if (valid)
        begin
            if (last_byte)
                byte_count <= 2'd0;
            else
                byte_count <= byte_count + 2'd1;
        end
    end

    // With four flits per dword the first and last slot can never overlap
    if (pld_bits == 8)
    begin : g_chk
        a_first_not_last: assert property (@(posedge side_clk) disable iff (!side_rst_b)
            !(first_byte && last_byte));
    end

endmodule

// File: rtl/sb_egress_serializer.sv
`timescale 1ns/1ps
`include "sb_link_config.svh"

module sb_egress_serializer (
    input  logic                   side_clk,
    input  logic                   side_rst_b,
    input  logic                   tx_valid,
    output logic                   tx_ready,
    input  sb_link_pkg::sb_dword_t tx_data,
    output logic                   flit_valid,
    input  logic                   flit_ready,
    output sb_link_pkg::sb_flit_t  flit
);

    import sb_link_pkg::*;

    localparam int         pld_w      = `SB_PLD_BITS;
    // Index of the final slice of a dword
    localparam logic [1:0] last_slice = 2'((32 / pld_w) - 1);

    logic        busy;
    logic [1:0]  slice_cnt;
    logic [31:0] shreg;
    logic        dw_eom;
    logic        tx_xfer;
    logic        flit_xfer;

    assign tx_xfer   = tx_valid & tx_ready;
    assign flit_xfer = flit_valid & flit_ready;

    // Only one dword is held, a new one is taken once the last slice is gone
    assign tx_ready   = ~busy;
    assign flit_valid = busy;

    // The lowest slice of the shift register is always the one on the wire
    assign flit.pld = shreg[pld_w-1:0];
    // Eom of the dword marks only its final slice
    assign flit.eom = dw_eom & (slice_cnt == last_slice);

    // ----------------------------------------------------------------------
    // Control
    // ----------------------------------------------------------------------

    always_ff @(posedge side_clk or negedge side_rst_b)
    begin
        if (!side_rst_b)
        begin
            busy      <= 1'b0;
            slice_cnt <= 2'd0;
        end
        else if (tx_xfer)
        begin
            busy      <= 1'b1;
            slice_cnt <= 2'd0;
        end
        else if (flit_xfer)
        begin
            // Dropping busy after the final slice reopens tx_ready next cycle
            if (slice_cnt == last_slice)
                busy <= 1'b0;
            slice_cnt <= slice_cnt + 2'd1;
        end
    end

    // ----------------------------------------------------------------------
    // Payload
    // ----------------------------------------------------------------------

    always_ff @(posedge side_clk)
    begin
        if (tx_xfer)
        begin
            shreg  <= tx_data.data.raw;
            dw_eom <= tx_data.eom;
        end
        else if (flit_xfer)
        begin
            // Move the next slice down into the output position
            shreg <= shreg >> pld_w;
        end
    end

    // A stalled flit must not change under the receiver
    a_flit_stable: assert property (@(posedge side_clk) disable iff (!side_rst_b)
        (flit_valid && !flit_ready) |=> $stable(flit));

endmodule

// File: rtl/sb_ingress_deserializer.sv
`timescale 1ns/1ps
`include "sb_link_config.svh"

module sb_ingress_deserializer (
    input  logic                   side_clk,
    input  logic                   side_rst_b,
    input  logic                   flit_valid,
    output logic                   flit_ready,
    input  sb_link_pkg::sb_flit_t  flit,
    output logic                   dw_valid,
    input  logic                   dw_ready,
    output sb_link_pkg::sb_dword_t dw
);

    import sb_link_pkg::*;

    localparam int pld_w = `SB_PLD_BITS;
    localparam int flits = 32 / pld_w;

    logic                       flit_xfer;
    logic                       first_byte;
    logic                       second_byte;
    logic                       third_byte;
    logic                       last_byte;
    logic [3:0]                 slot_mark;
    logic [flits-1:0][pld_w-1:0] asm_q;
    logic                       eom_q;
    logic                       full;

    assign flit_xfer = flit_valid & flit_ready;

    // Flit position within the dword being rebuilt
    sb_byte_count #(
        .pld_bits    (pld_w)
    ) sb_byte_count_i (
        .side_clk    (side_clk),
        .side_rst_b  (side_rst_b),
        .valid       (flit_xfer),
        .first_byte  (first_byte),
        .second_byte (second_byte),
        .third_byte  (third_byte),
        .last_byte   (last_byte)
    );

    // Slot marks, lowest slot first
    // At 16 bits only slot 0 and the last mark are needed
    assign slot_mark = {last_byte, third_byte, second_byte, first_byte};

    // No new flit is taken while a finished dword waits for the filter
    assign flit_ready = ~full;
    assign dw_valid   = full;

    assign dw.data.raw = asm_q;
    assign dw.eom      = eom_q;

    // ----------------------------------------------------------------------
    // Assembly
    // ----------------------------------------------------------------------

    always_ff @(posedge side_clk)
    begin
        if (flit_xfer)
        begin
            for (int k = 0; k < flits; k++)
            begin
                // The final slot always follows the last mark
                if ((k == flits - 1) ? slot_mark[3] : slot_mark[k])
                    asm_q[k] <= flit.pld;
            end
            if (last_byte)
                eom_q <= flit.eom;
        end
    end

    always_ff @(posedge side_clk or negedge side_rst_b)
    begin
        if (!side_rst_b)
            full <= 1'b0;
        else if (flit_xfer && last_byte)
            full <= 1'b1;
        else if (dw_ready)
            full <= 1'b0;
    end

    // Sender and receiver must agree on where a dword ends
    a_eom_on_last: assert property (@(posedge side_clk) disable iff (!side_rst_b)
        (flit_xfer && flit.eom) |-> last_byte);

endmodule

// File: rtl/sb_msg_filter.sv
`timescale 1ns/1ps
`include "sb_link_config.svh"

module sb_msg_filter (
    input  logic                   side_clk,
    input  logic                   side_rst_b,
    input  logic                   dw_valid,
    output logic                   dw_ready,
    input  sb_link_pkg::sb_dword_t dw,
    output logic                   rx_valid,
    input  logic                   rx_ready,
    output sb_link_pkg::sb_rx_t    rx_data
);

    import sb_link_pkg::*;

    logic sop;
    logic keep;
    logic dest_hit;
    logic pass;
    logic dw_xfer;

    // ----------------------------------------------------------------------
    // Header decode
    // ----------------------------------------------------------------------

    // Only meaningful when sop is set, the union is then read as a header
    assign dest_hit = (dw.data.hdr.dest == `SB_LOCAL_PORT);

    // The header decides for itself, later dwords reuse the stored result
    assign pass = sop ? dest_hit : keep;

    // The output register can take a dword if it is empty or draining now
    // Dropped dwords go through the same handshake and simply vanish
    assign dw_ready = ~rx_valid | rx_ready;
    assign dw_xfer  = dw_valid & dw_ready;

    // ----------------------------------------------------------------------
    // Message tracking
    // ----------------------------------------------------------------------

    always_ff @(posedge side_clk or negedge side_rst_b)
    begin
        if (!side_rst_b)
        begin
            sop  <= 1'b1;
            keep <= 1'b0;
        end
        else if (dw_xfer)
        begin
            // Whatever follows an eom is the header of the next message
            sop <= dw.eom;
            if (sop)
                keep <= dest_hit;
        end
    end

    // ----------------------------------------------------------------------
    // Output register
    // ----------------------------------------------------------------------

    always_ff @(posedge side_clk or negedge side_rst_b)
    begin
        if (!side_rst_b)
            rx_valid <= 1'b0;
        else if (dw_xfer && pass)
            rx_valid <= 1'b1;
        else if (rx_ready)
            rx_valid <= 1'b0;
    end

    always_ff @(posedge side_clk)
    begin
        if (dw_xfer && pass)
        begin
            rx_data.data      <= dw.data;
            rx_data.eom       <= dw.eom;
            rx_data.is_header <= sop;
        end
    end

    // Held output stays put until the agent takes it
    a_rx_stable: assert property (@(posedge side_clk) disable iff (!side_rst_b)
        (rx_valid && !rx_ready) |=> (rx_valid && $stable(rx_data)));

endmodule

// File: rtl/sb_link_top.sv
`timescale 1ns/1ps

module sb_link_top (
    input  logic                   side_clk,
    input  logic                   side_rst_b,
    input  logic                   tx_valid,
    output logic                   tx_ready,
    input  sb_link_pkg::sb_dword_t tx_data,
    output logic                   rx_valid,
    input  logic                   rx_ready,
    output sb_link_pkg::sb_rx_t    rx_data
);

    import sb_link_pkg::*;

    // Narrow channel between egress and ingress
    logic      flit_valid;
    logic      flit_ready;
    sb_flit_t  flit;

    // Rebuilt dwords on their way to the filter
    logic      dw_valid;
    logic      dw_ready;
    sb_dword_t dw;

    // ----------------------------------------------------------------------
    // Egress, looped straight back into ingress
    // ----------------------------------------------------------------------

    sb_egress_serializer sb_egress_serializer_i (
        .side_clk   (side_clk),
        .side_rst_b (side_rst_b),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .tx_data    (tx_data),
        .flit_valid (flit_valid),
        .flit_ready (flit_ready),
        .flit       (flit)
    );

    sb_ingress_deserializer sb_ingress_deserializer_i (
        .side_clk   (side_clk),
        .side_rst_b (side_rst_b),
        .flit_valid (flit_valid),
        .flit_ready (flit_ready),
        .flit       (flit),
        .dw_valid   (dw_valid),
        .dw_ready   (dw_ready),
        .dw         (dw)
    );

    // Local messages only reach the agent
    sb_msg_filter sb_msg_filter_i (
        .side_clk   (side_clk),
        .side_rst_b (side_rst_b),
        .dw_valid   (dw_valid),
        .dw_ready   (dw_ready),
        .dw         (dw),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .rx_data    (rx_data)
    );

endmodule

// File: test/sb_link_tb.sv
`timescale 1ns/1ps
`include "sb_link_config.svh"

module sb_link_tb;

    import sb_link_pkg::*;

    // The watchdog is sized by the number of messages over all phases
    localparam int n_msgs = 26;
    localparam int flits  = 32 / `SB_PLD_BITS;

    logic      side_clk;
    logic      side_rst_b;
    logic      tx_valid;
    logic      tx_ready;
    sb_dword_t tx_data;
    logic      rx_valid;
    logic      rx_ready;
    sb_rx_t    rx_data;

    // Scoreboard state
    sb_rx_t      exp_q[$];
    sb_rx_t      exp_head;
    logic        exp_empty;
    logic        next_hdr;
    sb_rx_t      prev_rx;
    logic        rx_random;
    logic [15:0] data_lfsr;
    logic [15:0] ready_lfsr;
    string       test_name;
    int          errors;
    int          pushed;
    int          delivered;
    int          msgs_sent;

    sb_link_top sb_link_top_i (
        .side_clk   (side_clk),
        .side_rst_b (side_rst_b),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .tx_data    (tx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .rx_data    (rx_data)
    );

    always #50 side_clk = ~side_clk;

    // ----------------------------------------------------------------------
    // Random source
    // ----------------------------------------------------------------------

    // 16-bit Fibonacci LFSR with taps 16 14 13 11 and its output at the top bit
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // The LFSR steps once per bit and the bits fill the low n bits MSB first
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[30:0], data_lfsr[15]};
            data_lfsr = lfsr_step(data_lfsr);
        end
        return r;
    endfunction

    // Any port id other than the local one
    function automatic logic [7:0] foreign_port();
        logic [7:0] p;
        p = 8'(rand_bits(8));
        if (p == `SB_LOCAL_PORT)
            p = p ^ 8'h01;
        return p;
    endfunction

    // ----------------------------------------------------------------------
    // Stimulus and bookkeeping
    // ----------------------------------------------------------------------

    task refresh_head();
        if (exp_q.size() > 0)
        begin
            exp_head  = exp_q[0];
            exp_empty = 1'b0;
        end
        else
        begin
            exp_head  = '0;
            exp_empty = 1'b1;
        end
    endtask

    // Pushes one message a dword at a time and is called 1 ns after a rising edge
    task send_msg(input logic [7:0] dest, input int len);
        logic [31:0] word;
        sb_rx_t      e;
        for (int i = 0; i < len; i++)
        begin
            if (i == 0)
                word = {dest, 24'(rand_bits(24))};
            else
                word = rand_bits(32);
            // Only local messages come back and each dword carries its position
            if (dest == `SB_LOCAL_PORT)
            begin
                e.data.raw = word;
                e.eom       = (i == len - 1);
                e.is_header = (i == 0);
                exp_q.push_back(e);
                pushed++;
                refresh_head();
            end
            tx_data.data.raw = word;
            tx_data.eom      = (i == len - 1);
            tx_valid         = 1'b1;
            // tx_ready only moves on an edge, so it is read in mid cycle
            while (!tx_ready)
            begin
                @(posedge side_clk);
                #1;
            end
            @(posedge side_clk);
            #1;
        end
        tx_valid = 1'b0;
        msgs_sent++;
    endtask

    // Waits until every expected dword came out, then lets the pipeline settle
    task wait_drain();
        while (exp_q.size() != 0)
            @(posedge side_clk);
        repeat (flits + 3) @(posedge side_clk);
        #1;
    endtask

    task print_summary();
        $display("Summary: %0d messages sent, %0d dwords expected, %0d delivered, %0d errors",
                 msgs_sent, pushed, delivered, errors);
    endtask

    // rx_ready is either held high or drawn from its own LFSR stream
    initial
    begin
        forever
        begin
            @(posedge side_clk);
            #1;
            if (rx_random)
            begin
                rx_ready   = ready_lfsr[15];
                ready_lfsr = lfsr_step(ready_lfsr);
            end
            else
                rx_ready = 1'b1;
        end
    end

    // Pops the expected queue after each rx transfer at a point away from the edge
    initial
    begin : monitor
        logic   took;
        sb_rx_t seen;
        forever
        begin
            @(negedge side_clk);
            took = side_rst_b && rx_valid && rx_ready;
            seen = rx_data;
            @(posedge side_clk);
            #2;
            prev_rx = seen;
            if (took)
            begin
                if (exp_q.size() > 0)
                begin
                    next_hdr = exp_q[0].eom;
                    exp_q.pop_front();
                end
                delivered++;
                refresh_head();
            end
        end
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------

    a_reset_vals: assert property (@(posedge side_clk)
        (!side_rst_b || $rose(side_rst_b)) |-> (!rx_valid && tx_ready))
        else
        begin
            errors++;
            $display("MISMATCH %s expected rx_valid=0 tx_ready=1 actual rx_valid=%b tx_ready=%b",
                     test_name, $sampled(rx_valid), $sampled(tx_ready));
        end

    // Every delivered dword must be the oldest one still expected
    a_rx_match: assert property (@(posedge side_clk) disable iff (!side_rst_b)
        (rx_valid && rx_ready) |-> (!exp_empty && rx_data == exp_head))
        else
        begin
            errors++;
            if ($sampled(exp_empty))
                $display("ERROR %s: a dword came out while none was expected", test_name);
            else
                $display("MISMATCH %s expected %h hdr=%b eom=%b actual %h hdr=%b eom=%b",
                         test_name, $sampled(exp_head.data.raw), $sampled(exp_head.is_header),
                         $sampled(exp_head.eom), $sampled(rx_data.data.raw),
                         $sampled(rx_data.is_header), $sampled(rx_data.eom));
        end

    // A header follows reset and every eom, and nothing else is a header
    a_hdr_order: assert property (@(posedge side_clk) disable iff (!side_rst_b)
        (rx_valid && rx_ready) |-> (rx_data.is_header == next_hdr))
        else
        begin
            errors++;
            $display("MISMATCH %s expected is_header=%b actual is_header=%b",
                     test_name, $sampled(next_hdr), $sampled(rx_data.is_header));
        end

    a_local_dest: assert property (@(posedge side_clk) disable iff (!side_rst_b)
        (rx_valid && rx_ready && rx_data.is_header) |->
            (rx_data.data.hdr.dest == `SB_LOCAL_PORT))
        else
        begin
            errors++;
            $display("MISMATCH %s expected dest %h actual dest %h",
                     test_name, `SB_LOCAL_PORT, $sampled(rx_data.data.hdr.dest));
        end

    a_rx_hold: assert property (@(posedge side_clk) disable iff (!side_rst_b)
        (rx_valid && !rx_ready) |=> (rx_valid && $stable(rx_data)))
        else
        begin
            errors++;
            $display("MISMATCH %s expected held %h valid=1 actual %h valid=%b", test_name,
                     $sampled(prev_rx.data.raw), $sampled(rx_data.data.raw), $sampled(rx_valid));
        end

    // Generous bound of 400 cycles per message plus the reset phase
    initial
    begin
        #(400 * n_msgs * 100 + 1000);
        errors++;
        $display("ERROR %s: timeout, the link did not finish in %0d cycles",
                 test_name, 400 * n_msgs + 10);
        print_summary();
        $display("TB FAILED");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial
    begin
        side_clk   = 1'b0;
        side_rst_b = 1'b0;
        tx_valid   = 1'b0;
        tx_data    = '0;
        rx_ready   = 1'b1;
        rx_random  = 1'b0;
        data_lfsr  = 16'd7;
        ready_lfsr = 16'd7;
        next_hdr   = 1'b1;
        prev_rx    = '0;
        errors     = 0;
        pushed     = 0;
        delivered  = 0;
        msgs_sent  = 0;
        test_name  = "reset";
        refresh_head();

        repeat (3) @(posedge side_clk);
        #1;
        side_rst_b = 1'b1;

        test_name = "local_basic";
        for (int m = 0; m < 4; m++)
            send_msg(`SB_LOCAL_PORT, 1 + int'(rand_bits(2)));
        wait_drain();

        // Each foreign message is chased by a local one
        test_name = "drop_foreign";
        for (int m = 0; m < 3; m++)
        begin
            send_msg(foreign_port(), 1 + int'(rand_bits(2)));
            send_msg(`SB_LOCAL_PORT, 1 + int'(rand_bits(2)));
        end
        wait_drain();

        test_name = "single_dword";
        send_msg(`SB_LOCAL_PORT, 1);
        send_msg(foreign_port(), 1);
        send_msg(`SB_LOCAL_PORT, 1);
        send_msg(`SB_LOCAL_PORT, 1);
        wait_drain();

        test_name = "back_pressure";
        rx_random = 1'b1;
        for (int m = 0; m < 12; m++)
        begin
            if (rand_bits(1) != 0)
                send_msg(`SB_LOCAL_PORT, 1 + int'(rand_bits(2)));
            else
                send_msg(foreign_port(), 1 + int'(rand_bits(2)));
        end
        rx_random = 1'b0;
        wait_drain();

        test_name = "end_of_run";
        a_all_out: assert (exp_q.size() == 0 && delivered == pushed && !rx_valid)
            else
            begin
                errors++;
                $display("MISMATCH %s expected %0d dwords, 0 left actual %0d dwords, %0d left",
                         test_name, pushed, delivered, exp_q.size());
            end

        print_summary();
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: sb_link.f
+incdir+include
rtl/sb_link_pkg.sv
rtl/sb_byte_count.sv
rtl/sb_egress_serializer.sv
rtl/sb_ingress_deserializer.sv
rtl/sb_msg_filter.sv
rtl/sb_link_top.sv
test/sb_link_tb.sv

// File: run.sh
#!/bin/sh
# Build the sideband link testbench with Verilator and run it.
# The run counts as passed only when the pass line appears in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sb_link_tb -f sb_link.f -Mdir obj_dir \
    && ./obj_dir/Vsb_link_tb | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
